// File: bench/tbBusTasks.svh
// ------------------------------
// LCG, address helpers, bus access task
// and value checks for the testbench
// ------------------------------

`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// Classic 32-bit LCG step
function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Region in bits 16:13, word index in bits 8:2, bits 12:9 unused
function automatic logic [apertureWidth-1:0] byteAdr(
    input logic [3:0]              region,
    input logic [regAddrWidth-1:0] idx
);
    return {region, 4'b0000, idx, 2'b00};
endfunction

function automatic logic [apertureWidth-1:0] regAdr(input logic [regAddrWidth-1:0] idx);
    return byteAdr(regRegion, idx);
endfunction

function automatic logic [apertureWidth-1:0] resAdr(input logic [regAddrWidth-1:0] idx);
    return byteAdr(reservedRegion, idx);
endfunction

task automatic checkValue(
    input string       name,
    input logic [31:0] got,
    input logic [31:0] exp
);
    assert (got === exp)
    else
        failRun($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
endtask

// ------------------------------
// One transfer, called at a falling edge
// ------------------------------
task automatic busAccess(
    input  logic                     isWrite,
    input  logic [apertureWidth-1:0] accAdr,
    input  logic [3:0]               accSel,
    input  logic [dataWidth-1:0]     accDat,
    output logic [dataWidth-1:0]     gotDat,
    output int                       edges
);
    logic ackSeen;
    ackSeen = 1'b0;
    edges   = 0;
    adr     = accAdr;
    byteStb = accSel;
    wrDat   = accDat;
    we      = isWrite;
    cyc     = 1'b1;
    stb     = 1'b1;
    // 12 cycles leave margin over the 8 cycle timeout
    while (!ackSeen && edges < 12)
    begin
        @(posedge wbClk);
        edges++;
        // Outputs settled half a cycle after the edge
        @(negedge wbClk);
        ackSeen = ack;
    end
    assert (ackSeen)
    else
        failRun($sformatf("No acknowledge within 12 cycles for address 0x%h", accAdr));
    gotDat = rdDat;
    cyc    = 1'b0;
    stb    = 1'b0;
    we     = 1'b0;
    // Idle cycle, ack must be a single pulse
    @(negedge wbClk);
    checkValue("ack_o", 32'(ack), 32'h0);
endtask

`endif

// File: bench/fpgaIpTb.sv
// ------------------------------
// Testbench of the FPGA IP top: clock, reset,
// watchdog and the stimulus table loop
// ------------------------------

`timescale 1ns/1ps

module fpgaIpTb;

    import fpgaIpPkg::*;

    typedef enum logic [1:0] {
        opRead,
        opWrite,
        // Expected data is the value on gpioIn_i
        opReadGpioIn
    } tbOp_t;

    // dat is write data or expected read data
    // pins is {gpioOut_o, gpioOe_o, 6'b0, clk1mCntl_o, clk4mCntl_o}
    typedef struct packed {
        tbOp_t                    op;
        logic [apertureWidth-1:0] adr;
        logic [3:0]               sel;
        logic [dataWidth-1:0]     dat;
        int                       lat;
        logic [23:0]              pins;
    } stimEntry_t;

    logic                     wbClk;
    logic                     rstN;
    logic [apertureWidth-1:0] adr;
    logic                     cyc;
    logic [3:0]               byteStb;
    logic                     we;
    logic                     stb;
    logic [dataWidth-1:0]     wrDat;
    logic [dataWidth-1:0]     rdDat;
    logic                     ack;
    logic [gpioWidth-1:0]     gpioIn;
    logic [gpioWidth-1:0]     gpioOut;
    logic [gpioWidth-1:0]     gpioOe;
    logic                     clk4mCntl;
    logic                     clk1mCntl;
    logic [31:0]              lcgState;
    stimEntry_t               tbl [25];

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    `include "tbBusTasks.svh"

    // ------------------------------
    // Stimulus table
    // ------------------------------
    task automatic loadTable();
        // ID words after reset
        tbl[0]  = '{opRead,  regAdr(regDeviceId),      4'hF, deviceIdValue,   1, 24'h00_00_00};
        tbl[1]  = '{opRead,  regAdr(regRevNum),        4'hF, revLevelValue,   1, 24'h00_00_00};
        // GPIO and clock-control writes with readback
        tbl[2]  = '{opWrite, regAdr(regGpioOut),       4'h1, 32'h0000_00A5,   1, 24'hA5_00_00};
        tbl[3]  = '{opRead,  regAdr(regGpioOut),       4'hF, 32'h0000_00A5,   1, 24'hA5_00_00};
        tbl[4]  = '{opWrite, regAdr(regGpioOe),        4'hF, 32'h1234_563C,   1, 24'hA5_3C_00};
        tbl[5]  = '{opRead,  regAdr(regGpioOe),        4'hF, 32'h0000_003C,   1, 24'hA5_3C_00};
        tbl[6]  = '{opWrite, regAdr(regClkCntl),       4'h1, 32'h0000_0003,   1, 24'hA5_3C_03};
        tbl[7]  = '{opWrite, regAdr(regClkCntl),       4'h1, 32'h0000_0002,   1, 24'hA5_3C_02};
        tbl[8]  = '{opRead,  regAdr(regClkCntl),       4'hF, 32'h0000_0002,   1, 24'hA5_3C_02};
        // Lane 0 strobe clear, register keeps A5
        tbl[9]  = '{opWrite, regAdr(regGpioOut),       4'hE, 32'h0000_00FF,   1, 24'hA5_3C_02};
        tbl[10] = '{opRead,  regAdr(regGpioOut),       4'hF, 32'h0000_00A5,   1, 24'hA5_3C_02};
        // GPIO input and undefined index
        tbl[11] = '{opReadGpioIn, regAdr(regGpioIn),   4'hF, 32'h0,           1, 24'hA5_3C_02};
        tbl[12] = '{opReadGpioIn, regAdr(regGpioIn),   4'hF, 32'h0,           1, 24'hA5_3C_02};
        tbl[13] = '{opRead,  regAdr(7'h10),            4'hF, regDefaultValue, 1, 24'hA5_3C_02};
        // Reserved block
        tbl[14] = '{opRead,  resAdr(resCustProdAdr),   4'hF, custProdValue,   1, 24'hA5_3C_02};
        tbl[15] = '{opRead,  resAdr(resRevisionsAdr),  4'hF, revisionsValue,  1, 24'hA5_3C_02};
        tbl[16] = '{opRead,  resAdr(7'h05),            4'hF, resDefaultValue, 1, 24'hA5_3C_02};
        tbl[17] = '{opWrite, resAdr(7'h05),            4'hF, 32'hFFFF_FFFF,   1, 24'hA5_3C_02};
        tbl[18] = '{opRead,  resAdr(7'h05),            4'hF, resDefaultValue, 1, 24'hA5_3C_02};
        // Unmapped regions answered by the timeout
        tbl[19] = '{opRead,  byteAdr(4'h1, 7'h00),     4'hF, badAccessValue,  8, 24'hA5_3C_02};
        tbl[20] = '{opWrite, byteAdr(4'h1, regGpioOut), 4'hF, 32'h0000_0077,  8, 24'hA5_3C_02};
        tbl[21] = '{opRead,  regAdr(regGpioOut),       4'hF, 32'h0000_00A5,   1, 24'hA5_3C_02};
        tbl[22] = '{opWrite, byteAdr(4'h2, regClkCntl), 4'hF, 32'h0000_0000,  8, 24'hA5_3C_02};
        tbl[23] = '{opRead,  regAdr(regClkCntl),       4'hF, 32'h0000_0002,   1, 24'hA5_3C_02};
        tbl[24] = '{opRead,  byteAdr(4'hF, 7'h7E),     4'hF, badAccessValue,  8, 24'hA5_3C_02};
    endtask

    // DUT
    fpgaIpTop u_dut (
        .wbClk_i     (wbClk),
        .rstN_i      (rstN),
        .adr_i       (adr),
        .cyc_i       (cyc),
        .byteStb_i   (byteStb),
        .we_i        (we),
        .stb_i       (stb),
        .wrDat_i     (wrDat),
        .rdDat_o     (rdDat),
        .ack_o       (ack),
        .gpioIn_i    (gpioIn),
        .gpioOut_o   (gpioOut),
        .gpioOe_o    (gpioOe),
        .clk4mCntl_o (clk4mCntl),
        .clk1mCntl_o (clk1mCntl)
    );

    // 100 ns period
    always #50 wbClk = ~wbClk;

    // Worst case per entry, plus reset and margin
    initial
    begin
        repeat ($size(tbl) * 12 + 20) @(posedge wbClk);
        failRun("Watchdog expired before the stimulus table finished");
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial
    begin
        stimEntry_t           e;
        logic [dataWidth-1:0] got;
        int                   edges;
        wbClk    = 1'b0;
        rstN     = 1'b0;
        adr      = '0;
        cyc      = 1'b0;
        byteStb  = 4'h0;
        we       = 1'b0;
        stb      = 1'b0;
        wrDat    = '0;
        gpioIn   = '0;
        lcgState = 32'ha7b82893;
        loadTable();
        // Reset for 2 cycles, released on a falling edge
        repeat (2) @(posedge wbClk);
        @(negedge wbClk);
        rstN = 1'b1;
        checkValue("ack_o", 32'(ack), 32'h0);
        checkValue("gpioOut_o", 32'(gpioOut), 32'h0);
        checkValue("gpioOe_o", 32'(gpioOe), 32'h0);
        checkValue("clk4mCntl_o", 32'(clk4mCntl), 32'h0);
        checkValue("clk1mCntl_o", 32'(clk1mCntl), 32'h0);
        foreach (tbl[i])
        begin
            e        = tbl[i];
            // Fresh GPIO input each entry
            lcgState = lcgNext(lcgState);
            gpioIn   = lcgState[31:24];
            busAccess(e.op == opWrite, e.adr, e.sel, e.dat, got, edges);
            checkValue("ack_o latency", 32'(edges), 32'(e.lat));
            if (e.op == opRead)
                checkValue("rdDat_o", got, e.dat);
            else if (e.op == opReadGpioIn)
                checkValue("rdDat_o", got, 32'(gpioIn));
            checkValue("gpioOut_o", 32'(gpioOut), 32'(e.pins[23:16]));
            checkValue("gpioOe_o", 32'(gpioOe), 32'(e.pins[15:8]));
            checkValue("clk1mCntl_o", 32'(clk1mCntl), 32'(e.pins[1]));
            checkValue("clk4mCntl_o", 32'(clk4mCntl), 32'(e.pins[0]));
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: build.sh
#!/bin/sh
# Compile and run the FPGA IP testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
    --top-module fpgaIpTb -f fpgaIp.f \
    --Mdir obj_dir -o fpgaIpSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fpgaIpSim > sim.log 2>&1
simStatus=$?
cat sim.log

# Log decides pass or fail
if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $simStatus -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
    exit 1
fi

echo "Simulation passed"
exit 0

// File: fpgaIp.f
+incdir+bench
src/fpgaIpPkg.sv
src/wbSlaveIf.sv
src/wbAddrDecode.sv
src/fpgaRegisters.sv
src/qlReserved.sv
src/fpgaIpTop.sv
bench/fpgaIpTb.sv

// File: src/fpgaIpPkg.sv
// ------------------------------
// Widths, address map, register indices,
// fixed read values and enums of the FPGA IP
// ------------------------------

package fpgaIpPkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int apertureWidth = 17;
    localparam int dataWidth     = 32;
    // Region field is adr[16:13]
    localparam int regionLsb     = 13;
    // Word index from adr[8:2]
    localparam int regAddrWidth  = 7;
    localparam int gpioWidth     = 8;

    // ------------------------------
    // Address map
    // ------------------------------
    // 8 KB regions, RAM regions 1..5 now unmapped
    typedef enum logic [apertureWidth-regionLsb-1:0] {
        regRegion      = 4'd0,
        reservedRegion = 4'd6
    } region_t;

    // General register word indices
    typedef enum logic [regAddrWidth-1:0] {
        regDeviceId = 7'h00,
        regRevNum   = 7'h01,
        regGpioIn   = 7'h02,
        regGpioOut  = 7'h03,
        regGpioOe   = 7'h04,
        regClkCntl  = 7'h05
    } regAddr_t;

    // Identification words at the top of the reserved block
    localparam logic [regAddrWidth-1:0] resCustProdAdr  = 7'h7E;
    localparam logic [regAddrWidth-1:0] resRevisionsAdr = 7'h7F;

    // ------------------------------
    // Fixed read values
    // ------------------------------
    localparam logic [dataWidth-1:0] deviceIdValue   = 32'h0000_0000;
    localparam logic [dataWidth-1:0] revLevelValue   = 32'h0000_0000;
    // Customer 01, product 00
    localparam logic [dataWidth-1:0] custProdValue   = 32'h0000_0100;
    // Major rev 1, minor rev 0
    localparam logic [dataWidth-1:0] revisionsValue  = 32'h0001_0000;
    // Marker values, easy to spot in a bus trace
    localparam logic [dataWidth-1:0] regDefaultValue = 32'hFABD_EFAC;
    localparam logic [dataWidth-1:0] resDefaultValue = 32'hDEFF_ABAC;
    localparam logic [dataWidth-1:0] badAccessValue  = 32'hBADF_ABAC;

    // ------------------------------
    // Bus timeout
    // ------------------------------
    localparam int timeoutWidth = 3;
    localparam logic [timeoutWidth-1:0] timeoutCount = 3'd7;

    typedef enum logic {
        toIdle,
        toCount
    } timeoutState_t;

endpackage

// File: src/fpgaIpTop.sv
// ------------------------------
// FPGA IP top: decoder, registers, reserved block
// ------------------------------

`timescale 1ns/1ps

module fpgaIpTop (
    input  logic                                wbClk_i,
    input  logic                                rstN_i,
    // Bridge bus
    input  logic [fpgaIpPkg::apertureWidth-1:0] adr_i,
    input  logic                                cyc_i,
    input  logic [3:0]                          byteStb_i,
    input  logic                                we_i,
    input  logic                                stb_i,
    input  logic [fpgaIpPkg::dataWidth-1:0]     wrDat_i,
    output logic [fpgaIpPkg::dataWidth-1:0]     rdDat_o,
    output logic                                ack_o,
    // GPIO, pad cells outside
    input  logic [fpgaIpPkg::gpioWidth-1:0]     gpioIn_i,
    output logic [fpgaIpPkg::gpioWidth-1:0]     gpioOut_o,
    output logic [fpgaIpPkg::gpioWidth-1:0]     gpioOe_o,
    // Clock enables
    output logic                                clk4mCntl_o,
    output logic                                clk1mCntl_o
);

    // Per-slave buses
    wbSlaveIf regBus ();
    wbSlaveIf resBus ();

    logic timeoutAck;

    // ------------------------------
    // Decode and mux
    // ------------------------------
    wbAddrDecode u_decode (
        .adr_i        (adr_i),
        .cyc_i        (cyc_i),
        .byteStb_i    (byteStb_i),
        .we_i         (we_i),
        .stb_i        (stb_i),
        .wrDat_i      (wrDat_i),
        .timeoutAck_i (timeoutAck),
        .regBus       (regBus.master),
        .resBus       (resBus.master),
        .rdDat_o      (rdDat_o),
        .ack_o        (ack_o)
    );

    // ------------------------------
    // Slaves
    // ------------------------------
    fpgaRegisters u_registers (
        .wbClk_i     (wbClk_i),
        .rstN_i      (rstN_i),
        .bus         (regBus.slave),
        .gpioIn_i    (gpioIn_i),
        .gpioOut_o   (gpioOut_o),
        .gpioOe_o    (gpioOe_o),
        .clk4mCntl_o (clk4mCntl_o),
        .clk1mCntl_o (clk1mCntl_o)
    );

    // Timer watches the raw strobe and the merged ack
    qlReserved u_reserved (
        .wbClk_i      (wbClk_i),
        .rstN_i       (rstN_i),
        .bus          (resBus.slave),
        .busCyc_i     (cyc_i),
        .busStb_i     (stb_i),
        .busAck_i     (ack_o),
        .timeoutAck_o (timeoutAck)
    );

endmodule

// File: src/fpgaRegisters.sv
// ------------------------------
// General registers: ID, revision,
// GPIO and clock-control enables
// ------------------------------

`timescale 1ns/1ps

module fpgaRegisters (
    input  logic                            wbClk_i,
    input  logic                            rstN_i,
    // Bus from the decoder
    wbSlaveIf.slave                         bus,
    // GPIO pins, pads live outside
    input  logic [fpgaIpPkg::gpioWidth-1:0] gpioIn_i,
    output logic [fpgaIpPkg::gpioWidth-1:0] gpioOut_o,
    output logic [fpgaIpPkg::gpioWidth-1:0] gpioOe_o,
    // Clock enables
    output logic                            clk4mCntl_o,
    output logic                            clk1mCntl_o
);

    import fpgaIpPkg::*;

    logic                 ackQ;
    logic                 accessDone;
    logic                 wrLowByte;
    logic [gpioWidth-1:0] gpioOutQ;
    logic [gpioWidth-1:0] gpioOeQ;
    logic [1:0]           clkCntlQ;
    regAddr_t             regAddr;

    assign regAddr = regAddr_t'(bus.adr);

    // ------------------------------
    // Handshake
    // ------------------------------
    // Access completes on the edge that raises ack
    assign accessDone = bus.cyc && bus.stb && !ackQ;

    always_ff @(posedge wbClk_i or negedge rstN_i)
    begin
        if (!rstN_i)
            ackQ <= 1'b0;
        else
            ackQ <= accessDone;
    end

    assign bus.ack = ackQ;

    // Only byte lane 0 holds register bits
    assign wrLowByte = accessDone && bus.we && bus.byteStb[0];

    // ------------------------------
    // Writable registers
    // ------------------------------
    always_ff @(posedge wbClk_i or negedge rstN_i)
    begin
        if (!rstN_i)
        begin
            gpioOutQ <= '0;
            gpioOeQ  <= '0;
            clkCntlQ <= '0;
        end
        else if (wrLowByte)
        begin
            case (regAddr)
                regGpioOut: gpioOutQ <= bus.wrDat[gpioWidth-1:0];
                regGpioOe:  gpioOeQ  <= bus.wrDat[gpioWidth-1:0];
                regClkCntl: clkCntlQ <= bus.wrDat[1:0];
                default:    ;
            endcase
        end
    end

    assign gpioOut_o   = gpioOutQ;
    assign gpioOe_o    = gpioOeQ;
    // Bit 0 gates the 4 MHz clock, bit 1 the 1 MHz clock
    assign clk4mCntl_o = clkCntlQ[0];
    assign clk1mCntl_o = clkCntlQ[1];

    // ------------------------------
    // Read mux
    // ------------------------------
    always_comb
    begin
        case (regAddr)
            regDeviceId: bus.rdDat = deviceIdValue;
            regRevNum:   bus.rdDat = revLevelValue;
            regGpioIn:   bus.rdDat = {{(dataWidth-gpioWidth){1'b0}}, gpioIn_i};
            regGpioOut:  bus.rdDat = {{(dataWidth-gpioWidth){1'b0}}, gpioOutQ};
            regGpioOe:   bus.rdDat = {{(dataWidth-gpioWidth){1'b0}}, gpioOeQ};
            regClkCntl:  bus.rdDat = {{(dataWidth-2){1'b0}}, clkCntlQ};
            // Unused index, marker value
            default:     bus.rdDat = regDefaultValue;
        endcase
    end

    // Read data follows adr, so adr holds through the ack cycle
    assert property (@(posedge wbClk_i) disable iff (!rstN_i)
        ackQ |-> $stable(bus.adr))
    else $error("fpgaRegisters address changed while ack high");

endmodule

// File: src/qlReserved.sv
// ------------------------------
// Reserved ID registers and
// timeout for unanswered strobes
// ------------------------------

`timescale 1ns/1ps

module qlReserved (
    input  logic    wbClk_i,
    input  logic    rstN_i,
    // Bus from the decoder
    wbSlaveIf.slave bus,
    // Unqualified bridge cycle, strobe and merged ack
    input  logic    busCyc_i,
    input  logic    busStb_i,
    input  logic    busAck_i,
    // Joins the merged ack
    output logic    timeoutAck_o
);

    import fpgaIpPkg::*;

    logic                    ackQ;
    logic                    pending;
    logic                    timeoutAckQ;
    logic [timeoutWidth-1:0] toCnt;
    timeoutState_t           toState;

    // ------------------------------
    // Register access
    // ------------------------------
    // Writes are dropped but still acknowledged
    always_ff @(posedge wbClk_i or negedge rstN_i)
    begin
        if (!rstN_i)
            ackQ <= 1'b0;
        else
            ackQ <= bus.cyc && bus.stb && !ackQ;
    end

    assign bus.ack = ackQ;

    always_comb
    begin
        if (bus.adr == resCustProdAdr)
            bus.rdDat = custProdValue;
        else if (bus.adr == resRevisionsAdr)
            bus.rdDat = revisionsValue;
        else
            bus.rdDat = resDefaultValue;
    end

    // ------------------------------
    // Timeout FSM
    // ------------------------------
    // Strobe waiting with nobody answering
    assign pending = busCyc_i && busStb_i && !busAck_i;

    // First waiting edge loads 1, edge 8 fires the ack
    always_ff @(posedge wbClk_i or negedge rstN_i)
    begin
        if (!rstN_i)
        begin
            toState     <= toIdle;
            toCnt       <= '0;
            timeoutAckQ <= 1'b0;
        end
        else
        begin
            timeoutAckQ <= 1'b0;
            case (toState)
                toIdle:
                begin
                    toCnt <= '0;
                    if (pending)
                    begin
                        toState <= toCount;
                        toCnt   <= timeoutWidth'(1);
                    end
                end
                toCount:
                begin
                    if (!pending)
                    begin
                        // Any ack seen, or strobe dropped
                        toState <= toIdle;
                        toCnt   <= '0;
                    end
                    else if (toCnt == timeoutCount)
                    begin
                        // Stay in toCount through the ack cycle
                        timeoutAckQ <= 1'b1;
                        toCnt       <= '0;
                    end
                    else
                        toCnt <= toCnt + 1'b1;
                end
                default:
                    toState <= toIdle;
            endcase
        end
    end

    assign timeoutAck_o = timeoutAckQ;

    // Own ack comes back on the merged ack and ends the count
    assert property (@(posedge wbClk_i) disable iff (!rstN_i)
        timeoutAckQ |=> (toState == toIdle))
    else $error("timeout FSM not idle after timeout ack");

endmodule

// File: src/wbAddrDecode.sv
// ------------------------------
// Region decode, cycle selects,
// read data mux and merged acknowledge
// ------------------------------

`timescale 1ns/1ps

module wbAddrDecode (
    // Bridge side
    input  logic [fpgaIpPkg::apertureWidth-1:0] adr_i,
    input  logic                                cyc_i,
    input  logic [3:0]                          byteStb_i,
    input  logic                                we_i,
    input  logic                                stb_i,
    input  logic [fpgaIpPkg::dataWidth-1:0]     wrDat_i,
    // Ack from the unanswered strobe timer
    input  logic                                timeoutAck_i,
    // Slave buses
    wbSlaveIf.master                            regBus,
    wbSlaveIf.master                            resBus,
    // Back to the bridge
    output logic [fpgaIpPkg::dataWidth-1:0]     rdDat_o,
    output logic                                ack_o
);

    import fpgaIpPkg::*;

    region_t region;

    // Top 4 address bits select an 8 KB region
    assign region = region_t'(adr_i[apertureWidth-1:regionLsb]);

    // ------------------------------
    // Fan out to the slaves
    // ------------------------------
    assign regBus.adr     = adr_i[regAddrWidth+1:2];
    assign regBus.byteStb = byteStb_i;
    assign regBus.we      = we_i;
    assign regBus.stb     = stb_i;
    assign regBus.wrDat   = wrDat_i;
    assign regBus.cyc     = cyc_i && (region == regRegion);

    assign resBus.adr     = adr_i[regAddrWidth+1:2];
    assign resBus.byteStb = byteStb_i;
    assign resBus.we      = we_i;
    assign resBus.stb     = stb_i;
    assign resBus.wrDat   = wrDat_i;
    assign resBus.cyc     = cyc_i && (region == reservedRegion);

    // ------------------------------
    // Read data and acknowledge
    // ------------------------------
    always_comb
    begin
        case (region)
            regRegion:      rdDat_o = regBus.rdDat;
            reservedRegion: rdDat_o = resBus.rdDat;
            // Former RAM regions and anything above
            default:        rdDat_o = badAccessValue;
        endcase
    end

    // Timeout ack covers unmapped regions
    assign ack_o = regBus.ack || resBus.ack || timeoutAck_i;

    // Only one responder acks a transfer
    always_comb
    begin
        assert ($onehot0({regBus.ack, resBus.ack, timeoutAck_i}))
        else $error("more than one acknowledge source active");
    end

endmodule

// File: src/wbSlaveIf.sv
// ------------------------------
// Bus signals between the decoder and one slave
// ------------------------------

`timescale 1ns/1ps

interface wbSlaveIf;

    import fpgaIpPkg::*;

    // Word index within the region
    logic [regAddrWidth-1:0] adr;
    logic [3:0]              byteStb;
    logic                    we;
    logic                    stb;
    logic [dataWidth-1:0]    wrDat;
    // Cycle select, already qualified by region
    logic                    cyc;
    // Combinational from adr
    logic [dataWidth-1:0]    rdDat;
    // One-cycle pulse per transfer
    logic                    ack;

    // Decoder side
    modport master (
        output adr, byteStb, we, stb, wrDat, cyc,
        input  rdDat, ack
    );

    // Register block side
    modport slave (
        input  adr, byteStb, we, stb, wrDat, cyc,
        output rdDat, ack
    );

endinterface
